/* design/mem_pkg.sv */
package mem_pkg;

  // Data and byte address width
  localparam int XLEN = 32;

  // Wishbone carries word addresses only
  localparam int ADR_W = XLEN - 2;

  // RAM depth in 32-bit words, and the index width that covers it
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW = $clog2(RAM_WORDS);

  // Access size, same encoding as the core's funct3 low bits
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {
    LSU_IDLE = 2'b00,
    LSU_REQ  = 2'b01,
    LSU_BUS  = 2'b10
  } lsu_state_e;

  typedef enum logic [1:0] {
    FETCH_IDLE = 2'b00,
    FETCH_REQ  = 2'b01,
    FETCH_BUS  = 2'b10
  } fetch_state_e;

  // Current holder of the shared bus
  typedef enum logic [1:0] {
    OWN_NONE  = 2'b00,
    OWN_FETCH = 2'b01,
    OWN_LSU   = 2'b10
  } bus_owner_e;

endpackage

/* design/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      start_i,
  input  logic [mem_pkg::XLEN-1:0]  addr_i,
  input  logic [mem_pkg::XLEN-1:0]  wdata_i,
  input  mem_pkg::mem_size_e        size_i,
  input  logic                      write_i,
  input  logic                      unsigned_i,
  output logic                      busy_o,
  output logic                      done_o,
  output logic [mem_pkg::XLEN-1:0]  rdata_o,
  output logic                      err_o,
  output logic                      req_o,
  input  logic                      grant_i,
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  output logic                      wb_we_o,
  output logic [mem_pkg::ADR_W-1:0] wb_adr_o,
  output logic [3:0]                wb_sel_o,
  output logic [mem_pkg::XLEN-1:0]  wb_dat_o,
  input  logic [mem_pkg::XLEN-1:0]  wb_dat_i,
  input  logic                      wb_ack_i,
  input  logic                      wb_err_i
);
  import mem_pkg::*;

  lsu_state_e      state_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;
  mem_size_e       size_q;
  logic            write_q;
  logic            unsigned_q;

  logic            misaligned;
  logic [3:0]      sel;
  logic [XLEN-1:0] lane_data;
  logic [XLEN-1:0] load_data;

  // Single master per cycle, so cyc simply follows stb
  assign wb_cyc_o = wb_stb_o;

  // Halfwords need an even address, words a multiple of four
  always_comb begin
    case (size_i)
      MEM_HALF: misaligned = addr_i[0];
      MEM_WORD: misaligned = |addr_i[1:0];
      default:  misaligned = 1'b0;
    endcase
  end

  // Byte lanes touched by the latched access
  always_comb begin
    case (size_q)
      MEM_HALF: sel = addr_q[1] ? 4'b1100 : 4'b0011;
      MEM_WORD: sel = 4'b1111;
      default:  sel = 4'b0001 << addr_q[1:0];
    endcase
  end

  // Bring the addressed lane down to bit 0 before extending
  assign lane_data = wb_dat_i >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (size_q)
      MEM_BYTE: load_data = unsigned_q ? {{(XLEN-8){1'b0}}, lane_data[7:0]}
                                       : {{(XLEN-8){lane_data[7]}}, lane_data[7:0]};
      MEM_HALF: load_data = unsigned_q ? {{(XLEN-16){1'b0}}, lane_data[15:0]}
                                       : {{(XLEN-16){lane_data[15]}}, lane_data[15:0]};
      default:  load_data = lane_data;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= LSU_IDLE;
      busy_o   <= 1'b0;
      done_o   <= 1'b0;
      err_o    <= 1'b0;
      req_o    <= 1'b0;
      wb_stb_o <= 1'b0;
      wb_we_o  <= 1'b0;
    end else begin
      // done and err are single-cycle pulses
      done_o <= 1'b0;
      err_o  <= 1'b0;
      case (state_q)
        LSU_IDLE: begin
          if (start_i) begin
            if (misaligned) begin
              // Rejected here, the bus never sees it
              done_o <= 1'b1;
              err_o  <= 1'b1;
            end else begin
              busy_o  <= 1'b1;
              req_o   <= 1'b1;
              state_q <= LSU_REQ;
            end
          end
        end
        LSU_REQ: begin
          if (grant_i) begin
            wb_stb_o <= 1'b1;
            wb_we_o  <= write_q;
            state_q  <= LSU_BUS;
          end
        end
        LSU_BUS: begin
          if (wb_ack_i || wb_err_i) begin
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
            req_o    <= 1'b0;
            busy_o   <= 1'b0;
            done_o   <= 1'b1;
            err_o    <= wb_err_i;
            state_q  <= LSU_IDLE;
          end
        end
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == LSU_IDLE && start_i) begin
      addr_q     <= addr_i;
      wdata_q    <= wdata_i;
      size_q     <= size_i;
      write_q    <= write_i;
      unsigned_q <= unsigned_i;
    end
    // Store data moves up into its lanes when the cycle starts
    if (state_q == LSU_REQ && grant_i) begin
      wb_adr_o <= addr_q[XLEN-1:2];
      wb_sel_o <= sel;
      wb_dat_o <= wdata_q << {addr_q[1:0], 3'b000};
    end
    if (state_q == LSU_BUS && wb_ack_i) begin
      rdata_o <= load_data;
    end
  end

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      start_i,
  input  logic [mem_pkg::XLEN-1:0]  pc_i,
  output logic                      busy_o,
  output logic                      done_o,
  output logic [mem_pkg::XLEN-1:0]  instr_o,
  output logic                      err_o,
  output logic                      req_o,
  input  logic                      grant_i,
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  output logic [mem_pkg::ADR_W-1:0] wb_adr_o,
  input  logic [mem_pkg::XLEN-1:0]  wb_dat_i,
  input  logic                      wb_ack_i,
  input  logic                      wb_err_i
);
  import mem_pkg::*;

  fetch_state_e state_q;

  assign wb_cyc_o = wb_stb_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= FETCH_IDLE;
      busy_o   <= 1'b0;
      done_o   <= 1'b0;
      err_o    <= 1'b0;
      req_o    <= 1'b0;
      wb_stb_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      err_o  <= 1'b0;
      case (state_q)
        FETCH_IDLE: begin
          if (start_i) begin
            // Instructions are word aligned, anything else faults at once
            if (|pc_i[1:0]) begin
              done_o <= 1'b1;
              err_o  <= 1'b1;
            end else begin
              busy_o  <= 1'b1;
              req_o   <= 1'b1;
              state_q <= FETCH_REQ;
            end
          end
        end
        FETCH_REQ: begin
          if (grant_i) begin
            wb_stb_o <= 1'b1;
            state_q  <= FETCH_BUS;
          end
        end
        FETCH_BUS: begin
          if (wb_ack_i || wb_err_i) begin
            wb_stb_o <= 1'b0;
            req_o    <= 1'b0;
            busy_o   <= 1'b0;
            done_o   <= 1'b1;
            err_o    <= wb_err_i;
            state_q  <= FETCH_IDLE;
          end
        end
        default: state_q <= FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == FETCH_IDLE && start_i) begin
      wb_adr_o <= pc_i[XLEN-1:2];
    end
    if (state_q == FETCH_BUS && wb_ack_i) begin
      instr_o <= wb_dat_i;
    end
  end

endmodule

/* design/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      lsu_req_i,
  input  logic                      fetch_req_i,
  output logic                      lsu_grant_o,
  output logic                      fetch_grant_o,
  input  logic                      lsu_cyc_i,
  input  logic                      lsu_stb_i,
  input  logic                      lsu_we_i,
  input  logic [mem_pkg::ADR_W-1:0] lsu_adr_i,
  input  logic [3:0]                lsu_sel_i,
  input  logic [mem_pkg::XLEN-1:0]  lsu_dat_i,
  input  logic                      fetch_cyc_i,
  input  logic                      fetch_stb_i,
  input  logic [mem_pkg::ADR_W-1:0] fetch_adr_i,
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  output logic                      wb_we_o,
  output logic [mem_pkg::ADR_W-1:0] wb_adr_o,
  output logic [3:0]                wb_sel_o,
  output logic [mem_pkg::XLEN-1:0]  wb_dat_o,
  input  logic                      wb_ack_i,
  input  logic                      wb_err_i,
  input  logic [mem_pkg::XLEN-1:0]  wb_dat_i,
  output logic [mem_pkg::XLEN-1:0]  rd_dat_o,
  output logic                      lsu_ack_o,
  output logic                      lsu_err_o,
  output logic                      fetch_ack_o,
  output logic                      fetch_err_o
);
  import mem_pkg::*;

  bus_owner_e owner_q;

  // Grant is held until the owner drops req, then the bus idles one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner_q <= OWN_NONE;
    end else begin
      case (owner_q)
        OWN_NONE: begin
          // Data accesses win a tie
          if (lsu_req_i) begin
            owner_q <= OWN_LSU;
          end else if (fetch_req_i) begin
            owner_q <= OWN_FETCH;
          end
        end
        OWN_LSU:   if (!lsu_req_i) owner_q <= OWN_NONE;
        OWN_FETCH: if (!fetch_req_i) owner_q <= OWN_NONE;
        default:   owner_q <= OWN_NONE;
      endcase
    end
  end

  assign lsu_grant_o   = (owner_q == OWN_LSU);
  assign fetch_grant_o = (owner_q == OWN_FETCH);

  always_comb begin
    case (owner_q)
      OWN_LSU: begin
        wb_cyc_o = lsu_cyc_i;
        wb_stb_o = lsu_stb_i;
        wb_we_o  = lsu_we_i;
        wb_adr_o = lsu_adr_i;
        wb_sel_o = lsu_sel_i;
        wb_dat_o = lsu_dat_i;
      end
      OWN_FETCH: begin
        // Fetch is always a full-word read
        wb_cyc_o = fetch_cyc_i;
        wb_stb_o = fetch_stb_i;
        wb_we_o  = 1'b0;
        wb_adr_o = fetch_adr_i;
        wb_sel_o = 4'b1111;
        wb_dat_o = '0;
      end
      default: begin
        wb_cyc_o = 1'b0;
        wb_stb_o = 1'b0;
        wb_we_o  = 1'b0;
        wb_adr_o = '0;
        wb_sel_o = 4'b0000;
        wb_dat_o = '0;
      end
    endcase
  end

  // Responses go only to the current owner
  assign lsu_ack_o   = wb_ack_i && (owner_q == OWN_LSU);
  assign lsu_err_o   = wb_err_i && (owner_q == OWN_LSU);
  assign fetch_ack_o = wb_ack_i && (owner_q == OWN_FETCH);
  assign fetch_err_o = wb_err_i && (owner_q == OWN_FETCH);
  assign rd_dat_o    = wb_dat_i;

endmodule

/* design/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [mem_pkg::ADR_W-1:0] wb_adr_i,
  input  logic [3:0]                wb_sel_i,
  input  logic [mem_pkg::XLEN-1:0]  wb_dat_i,
  output logic [mem_pkg::XLEN-1:0]  wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      wb_err_o
);
  import mem_pkg::*;

  logic [XLEN-1:0]  mem [RAM_WORDS];
  logic             resp_q;
  logic             access;
  logic             in_range;
  logic [RAM_AW-1:0] idx;

  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // A strobe is answered once, then ignored while the response is out
  assign access   = wb_cyc_i && wb_stb_i && !resp_q;
  assign in_range = (wb_adr_i < ADR_W'(RAM_WORDS));
  assign idx      = wb_adr_i[RAM_AW-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_q   <= 1'b0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      resp_q   <= access;
      wb_ack_o <= access && in_range;
      wb_err_o <= access && !in_range;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && in_range) begin
      if (wb_we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (wb_sel_i[b]) begin
            mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
          end
        end
      end
      wb_dat_o <= mem[idx];
    end
  end

endmodule

/* design/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     lsu_start_i,
  input  logic [mem_pkg::XLEN-1:0] lsu_addr_i,
  input  logic [mem_pkg::XLEN-1:0] lsu_wdata_i,
  input  mem_pkg::mem_size_e       lsu_size_i,
  input  logic                     lsu_write_i,
  input  logic                     lsu_unsigned_i,
  output logic                     lsu_busy_o,
  output logic                     lsu_done_o,
  output logic [mem_pkg::XLEN-1:0] lsu_rdata_o,
  output logic                     lsu_err_o,
  input  logic                     fetch_start_i,
  input  logic [mem_pkg::XLEN-1:0] fetch_pc_i,
  output logic                     fetch_busy_o,
  output logic                     fetch_done_o,
  output logic [mem_pkg::XLEN-1:0] fetch_instr_o,
  output logic                     fetch_err_o
);
  import mem_pkg::*;

  // Master side of the load/store unit
  logic             lsu_req, lsu_grant, lsu_cyc, lsu_stb, lsu_we, lsu_ack, lsu_err;
  logic [ADR_W-1:0] lsu_adr;
  logic [3:0]       lsu_sel;
  logic [XLEN-1:0]  lsu_dat;

  // Master side of the fetch unit
  logic             fetch_req, fetch_grant, fetch_cyc, fetch_stb, fetch_ack, fetch_err;
  logic [ADR_W-1:0] fetch_adr;

  // Slave side and shared read data
  logic             wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  logic [ADR_W-1:0] wb_adr;
  logic [3:0]       wb_sel;
  logic [XLEN-1:0]  wb_wdat, wb_rdat, rd_dat;

  load_store_unit lsu0 (
    .clk_i, .reset_i,
    .start_i(lsu_start_i), .addr_i(lsu_addr_i), .wdata_i(lsu_wdata_i),
    .size_i(lsu_size_i), .write_i(lsu_write_i), .unsigned_i(lsu_unsigned_i),
    .busy_o(lsu_busy_o), .done_o(lsu_done_o), .rdata_o(lsu_rdata_o), .err_o(lsu_err_o),
    .req_o(lsu_req), .grant_i(lsu_grant),
    .wb_cyc_o(lsu_cyc), .wb_stb_o(lsu_stb), .wb_we_o(lsu_we), .wb_adr_o(lsu_adr),
    .wb_sel_o(lsu_sel), .wb_dat_o(lsu_dat), .wb_dat_i(rd_dat),
    .wb_ack_i(lsu_ack), .wb_err_i(lsu_err)
  );

  fetch_unit fetch0 (
    .clk_i, .reset_i,
    .start_i(fetch_start_i), .pc_i(fetch_pc_i),
    .busy_o(fetch_busy_o), .done_o(fetch_done_o), .instr_o(fetch_instr_o),
    .err_o(fetch_err_o), .req_o(fetch_req), .grant_i(fetch_grant),
    .wb_cyc_o(fetch_cyc), .wb_stb_o(fetch_stb), .wb_adr_o(fetch_adr),
    .wb_dat_i(rd_dat), .wb_ack_i(fetch_ack), .wb_err_i(fetch_err)
  );

  bus_arbiter arb0 (
    .clk_i, .reset_i,
    .lsu_req_i(lsu_req), .fetch_req_i(fetch_req),
    .lsu_grant_o(lsu_grant), .fetch_grant_o(fetch_grant),
    .lsu_cyc_i(lsu_cyc), .lsu_stb_i(lsu_stb), .lsu_we_i(lsu_we),
    .lsu_adr_i(lsu_adr), .lsu_sel_i(lsu_sel), .lsu_dat_i(lsu_dat),
    .fetch_cyc_i(fetch_cyc), .fetch_stb_i(fetch_stb), .fetch_adr_i(fetch_adr),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_sel_o(wb_sel), .wb_dat_o(wb_wdat),
    .wb_ack_i(wb_ack), .wb_err_i(wb_err), .wb_dat_i(wb_rdat), .rd_dat_o(rd_dat),
    .lsu_ack_o(lsu_ack), .lsu_err_o(lsu_err),
    .fetch_ack_o(fetch_ack), .fetch_err_o(fetch_err)
  );

  wb_ram ram0 (
    .clk_i, .reset_i,
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_sel_i(wb_sel), .wb_dat_i(wb_wdat), .wb_dat_o(wb_rdat),
    .wb_ack_o(wb_ack), .wb_err_o(wb_err)
  );

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset held over the first 8 rising edges
  initial begin
    reset_o <= 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

/* bench/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;
  import mem_pkg::*;

  localparam int DONE_LIMIT = 20;
  localparam int NUM_ACCESSES = 120;
  localparam int TIMEOUT_CYCLES = NUM_ACCESSES * DONE_LIMIT + 100;

  typedef struct packed {
    logic [XLEN-1:0] data;
    logic            err;
    logic            check_data;
  } expect_t;

  logic            clk;
  logic            reset;
  logic            lsu_start;
  logic [XLEN-1:0] lsu_addr;
  logic [XLEN-1:0] lsu_wdata;
  mem_size_e       lsu_size;
  logic            lsu_write;
  logic            lsu_unsigned;
  logic            lsu_busy;
  logic            lsu_done;
  logic [XLEN-1:0] lsu_rdata;
  logic            lsu_err;
  logic            fetch_start;
  logic [XLEN-1:0] fetch_pc;
  logic            fetch_busy;
  logic            fetch_done;
  logic [XLEN-1:0] fetch_instr;
  logic            fetch_err;

  logic [XLEN-1:0] shadow [RAM_WORDS];
  expect_t         lsu_expect_q[$];
  expect_t         fetch_expect_q[$];
  int              error_count = 0;
  int              check_count = 0;
  int              tests_failed = 0;
  int              test_start_errors = 0;
  int              cycle_count = 0;

  tb_clock_gen clock0 (.clk_o(clk), .reset_o(reset));

  mem_subsystem dut0 (
    .clk_i(clk), .reset_i(reset),
    .lsu_start_i(lsu_start), .lsu_addr_i(lsu_addr), .lsu_wdata_i(lsu_wdata),
    .lsu_size_i(lsu_size), .lsu_write_i(lsu_write), .lsu_unsigned_i(lsu_unsigned),
    .lsu_busy_o(lsu_busy), .lsu_done_o(lsu_done), .lsu_rdata_o(lsu_rdata),
    .lsu_err_o(lsu_err), .fetch_start_i(fetch_start), .fetch_pc_i(fetch_pc),
    .fetch_busy_o(fetch_busy), .fetch_done_o(fetch_done),
    .fetch_instr_o(fetch_instr), .fetch_err_o(fetch_err)
  );

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      error_count++;
    end
  endtask

  function automatic logic out_of_range(input logic [XLEN-1:0] addr);
    return addr >= XLEN'(RAM_WORDS * 4);
  endfunction

  function automatic logic is_misaligned(input logic [XLEN-1:0] addr, input mem_size_e size);
    return (size == MEM_HALF && addr[0]) || (size == MEM_WORD && addr[1:0] != 2'b00);
  endfunction

  // Expected load result, built from the shadow copy of the RAM
  function automatic logic [XLEN-1:0] expected_load(input logic [XLEN-1:0] addr,
                                                    input mem_size_e size, input logic uns);
    logic [XLEN-1:0] word;
    logic [7:0]      b;
    logic [15:0]     h;
    word = shadow[addr[RAM_AW+1:2]];
    case (addr[1:0])
      2'd0: b = word[7:0];
      2'd1: b = word[15:8];
      2'd2: b = word[23:16];
      default: b = word[31:24];
    endcase
    h = addr[1] ? word[31:16] : word[15:0];
    case (size)
      MEM_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
      MEM_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
      default:  return word;
    endcase
  endfunction

  task automatic shadow_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                              input mem_size_e size);
    logic [RAM_AW-1:0] idx;
    idx = addr[RAM_AW+1:2];
    case (size)
      MEM_BYTE: shadow[idx][8*addr[1:0] +: 8] = wdata[7:0];
      MEM_HALF: shadow[idx][16*addr[1] +: 16] = wdata[15:0];
      default:  shadow[idx] = wdata;
    endcase
  endtask

  task automatic lsu_access(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                            input mem_size_e size, input logic write, input logic uns);
    expect_t e;
    int      cycles;
    logic    bad_align;
    bad_align = is_misaligned(addr, size);
    e.err = bad_align || out_of_range(addr);
    e.check_data = !write && !e.err;
    e.data = e.check_data ? expected_load(addr, size, uns) : '0;
    lsu_expect_q.push_back(e);
    @(posedge clk);
    lsu_start    <= 1'b1;
    lsu_addr     <= addr;
    lsu_wdata    <= wdata;
    lsu_size     <= size;
    lsu_write    <= write;
    lsu_unsigned <= uns;
    @(posedge clk);
    lsu_start <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      // Busy covers a bus access until done, and never rises for a rejected one
      check_value("lsu_busy_o", 32'(lsu_busy), 32'(!lsu_done && !bad_align));
    end while (!lsu_done && cycles < DONE_LIMIT);
    if (!lsu_done) begin
      $display("lsu_done_o never came within %0d cycles for address 0x%08h", DONE_LIMIT, addr);
      error_count++;
    end else begin
      // Rejected accesses finish at +1, bus accesses at +5
      check_value("lsu_done_o latency", 32'(cycles), bad_align ? 32'd1 : 32'd5);
    end
    if (write && !e.err) begin
      shadow_store(addr, wdata, size);
    end
  endtask

  task automatic fetch_access(input logic [XLEN-1:0] pc);
    expect_t e;
    int      cycles;
    logic    bad_align;
    bad_align = (pc[1:0] != 2'b00);
    e.err = bad_align || out_of_range(pc);
    e.check_data = !e.err;
    e.data = e.check_data ? expected_load(pc, MEM_WORD, 1'b0) : '0;
    fetch_expect_q.push_back(e);
    @(posedge clk);
    fetch_start <= 1'b1;
    fetch_pc    <= pc;
    @(posedge clk);
    fetch_start <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      check_value("fetch_busy_o", 32'(fetch_busy), 32'(!fetch_done && !bad_align));
    end while (!fetch_done && cycles < DONE_LIMIT);
    if (!fetch_done) begin
      $display("fetch_done_o never came within %0d cycles for pc 0x%08h", DONE_LIMIT, pc);
      error_count++;
    end else begin
      check_value("fetch_done_o latency", 32'(cycles), bad_align ? 32'd1 : 32'd5);
    end
  endtask

  // Word access on the data port and a fetch, both started on one edge
  task automatic concurrent_access(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                                   input logic write, input logic [XLEN-1:0] pc);
    expect_t le;
    expect_t fe;
    int      cycles;
    logic    lsu_seen;
    logic    fetch_seen;
    le.err = 1'b0;
    le.check_data = !write;
    le.data = expected_load(addr, MEM_WORD, 1'b0);
    fe.err = 1'b0;
    fe.check_data = 1'b1;
    fe.data = expected_load(pc, MEM_WORD, 1'b0);
    lsu_expect_q.push_back(le);
    fetch_expect_q.push_back(fe);
    @(posedge clk);
    lsu_start    <= 1'b1;
    lsu_addr     <= addr;
    lsu_wdata    <= wdata;
    lsu_size     <= MEM_WORD;
    lsu_write    <= write;
    lsu_unsigned <= 1'b0;
    fetch_start  <= 1'b1;
    fetch_pc     <= pc;
    @(posedge clk);
    lsu_start   <= 1'b0;
    fetch_start <= 1'b0;
    cycles = 0;
    lsu_seen = 1'b0;
    fetch_seen = 1'b0;
    do begin
      @(negedge clk);
      cycles++;
      if (lsu_done) lsu_seen = 1'b1;
      if (fetch_done) fetch_seen = 1'b1;
    end while (!(lsu_seen && fetch_seen) && cycles < 2 * DONE_LIMIT);
    if (!lsu_seen || !fetch_seen) begin
      $display("a port never finished the shared access to 0x%08h and 0x%08h", addr, pc);
      error_count++;
    end
    if (write) begin
      shadow_store(addr, wdata, MEM_WORD);
    end
  endtask

  task automatic end_test(input int num, input string name);
    @(negedge clk);
    if (error_count != test_start_errors) begin
      $display("test %0d %s: failed with %0d errors", num, name, error_count - test_start_errors);
      tests_failed++;
    end else begin
      $display("test %0d %s: ok", num, name);
    end
    test_start_errors = error_count;
  endtask

  // Compare each completion against the oldest expectation of its port
  always @(negedge clk) begin
    expect_t e;
    if (!reset && lsu_done) begin
      if (lsu_expect_q.size() == 0) begin
        $display("lsu_done_o pulsed at %0d ns with no access outstanding", $time);
        error_count++;
      end else begin
        e = lsu_expect_q.pop_front();
        check_value("lsu_err_o", 32'(lsu_err), 32'(e.err));
        if (e.check_data) check_value("lsu_rdata_o", lsu_rdata, e.data);
      end
    end
    if (!reset && fetch_done) begin
      if (fetch_expect_q.size() == 0) begin
        $display("fetch_done_o pulsed at %0d ns with no fetch outstanding", $time);
        error_count++;
      end else begin
        e = fetch_expect_q.pop_front();
        check_value("fetch_err_o", 32'(fetch_err), 32'(e.err));
        if (e.check_data) check_value("fetch_instr_o", fetch_instr, e.data);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    logic [XLEN-1:0] addrs [16];
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] data;
    void'($urandom(32'hd0eb_eec2));
    lsu_start    <= 1'b0;
    lsu_addr     <= '0;
    lsu_wdata    <= '0;
    lsu_size     <= MEM_WORD;
    lsu_write    <= 1'b0;
    lsu_unsigned <= 1'b0;
    fetch_start  <= 1'b0;
    fetch_pc     <= '0;
    for (int i = 0; i < RAM_WORDS; i++) begin
      shadow[i] = '0;
    end

    do @(negedge clk); while (reset);
    check_value("lsu_busy_o", 32'(lsu_busy), 32'd0);
    check_value("lsu_done_o", 32'(lsu_done), 32'd0);
    check_value("lsu_err_o", 32'(lsu_err), 32'd0);
    check_value("fetch_busy_o", 32'(fetch_busy), 32'd0);
    check_value("fetch_done_o", 32'(fetch_done), 32'd0);
    check_value("fetch_err_o", 32'(fetch_err), 32'd0);
    end_test(1, "idle outputs after reset");

    for (int i = 0; i < 16; i++) begin
      addrs[i] = ($urandom % RAM_WORDS) << 2;
      lsu_access(addrs[i], $urandom, MEM_WORD, 1'b1, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      lsu_access(addrs[i], '0, MEM_WORD, 1'b0, 1'b0);
    end
    end_test(2, "random word stores and loads");

    base = ($urandom % RAM_WORDS) << 2;
    lsu_access(base, $urandom, MEM_WORD, 1'b1, 1'b0);
    for (int off = 0; off < 4; off++) begin
      // Odd offsets carry a negative byte
      data = $urandom;
      data[7] = off[0];
      lsu_access(base + 32'(off), data, MEM_BYTE, 1'b1, 1'b0);
      lsu_access(base, '0, MEM_WORD, 1'b0, 1'b0);
    end
    for (int off = 0; off < 4; off += 2) begin
      data = $urandom;
      data[15] = off[1];
      lsu_access(base + 32'(off), data, MEM_HALF, 1'b1, 1'b0);
      lsu_access(base, '0, MEM_WORD, 1'b0, 1'b0);
    end
    for (int off = 0; off < 4; off++) begin
      lsu_access(base + 32'(off), '0, MEM_BYTE, 1'b0, 1'b0);
      lsu_access(base + 32'(off), '0, MEM_BYTE, 1'b0, 1'b1);
    end
    for (int off = 0; off < 4; off += 2) begin
      lsu_access(base + 32'(off), '0, MEM_HALF, 1'b0, 1'b0);
      lsu_access(base + 32'(off), '0, MEM_HALF, 1'b0, 1'b1);
    end
    lsu_access(base, '0, MEM_WORD, 1'b0, 1'b0);
    end_test(3, "byte and halfword lanes with extension");

    base = ($urandom % RAM_WORDS) << 2;
    lsu_access(base, $urandom, MEM_WORD, 1'b1, 1'b0);
    lsu_access(base + 32'd1, $urandom, MEM_HALF, 1'b1, 1'b0);
    lsu_access(base + 32'd3, $urandom, MEM_HALF, 1'b1, 1'b0);
    for (int off = 1; off < 4; off++) begin
      lsu_access(base + 32'(off), $urandom, MEM_WORD, 1'b1, 1'b0);
      fetch_access(base + 32'(off));
    end
    lsu_access(base + 32'd2, '0, MEM_WORD, 1'b0, 1'b0);
    lsu_access(base, '0, MEM_WORD, 1'b0, 1'b0);
    end_test(4, "misaligned accesses rejected");

    lsu_access(32'h0000_0400, $urandom, MEM_WORD, 1'b1, 1'b0);
    lsu_access(32'h0000_0405, $urandom, MEM_BYTE, 1'b1, 1'b0);
    lsu_access(32'hffff_fffc, $urandom, MEM_WORD, 1'b1, 1'b0);
    lsu_access(32'h0000_0800, '0, MEM_WORD, 1'b0, 1'b0);
    fetch_access(32'h0000_0400);
    fetch_access(32'h8000_0000);
    // Words that the rejected stores would alias onto
    lsu_access(32'h0000_0000, '0, MEM_WORD, 1'b0, 1'b0);
    lsu_access(32'h0000_0004, '0, MEM_WORD, 1'b0, 1'b0);
    lsu_access(32'h0000_03fc, '0, MEM_WORD, 1'b0, 1'b0);
    end_test(5, "out-of-range addresses");

    for (int i = 0; i < 8; i++) begin
      a = $urandom % RAM_WORDS;
      b = (a + 1 + ($urandom % (RAM_WORDS - 1))) % RAM_WORDS;
      concurrent_access(a << 2, $urandom, 1'b1, b << 2);
      concurrent_access(a << 2, '0, 1'b0, a << 2);
      lsu_access(a << 2, '0, MEM_WORD, 1'b0, 1'b0);
    end
    end_test(6, "fetch and data port contention");

    if (lsu_expect_q.size() != 0 || fetch_expect_q.size() != 0) begin
      $display("%0d data and %0d fetch results never arrived",
               lsu_expect_q.size(), fetch_expect_q.size());
      error_count++;
    end
    $display("6 tests run, %0d failed, %0d checks, %0d errors",
             tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* src.f */
design/mem_pkg.sv
design/load_store_unit.sv
design/fetch_unit.sv
design/bus_arbiter.sv
design/wb_ram.sv
design/mem_subsystem.sv
bench/tb_clock_gen.sv
bench/tb_mem_subsystem.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -sv -f src.f --top-module tb_mem_subsystem -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
